// ==== include/lockstep_settings.svh ====
// lockstep checker settings: memory depths and retire counter width
`ifndef LOCKSTEP_SETTINGS_SVH
`define LOCKSTEP_SETTINGS_SVH

// words per instruction bank, indexed by pc[5:2]
`define IMEM_WORDS 16

// data memory words per core, indexed by addr[5:2]
`define DMEM_WORDS 16

`define CYCLE_CNT_W 16 // retire counter width

`endif

// ==== design/lockstep_pkg.sv ====
// lockstep checker package: shared vector types, opcodes and monitor states
`include "lockstep_settings.svh"

package lockstep_pkg;

    // data, instruction and address words
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;  // x0..x31

    // word index into a 16-word memory, from address bits 5 to 2
    typedef logic [3:0] mem_index_t;

    typedef logic [`CYCLE_CNT_W-1:0] cycle_cnt_t;

    typedef logic [6:0] opcode_t;

    // supported major opcodes, everything else is a nop
    localparam opcode_t OP_ADDI  = 7'b0010011;
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    // divergence monitor FSM
    typedef enum logic [1:0] {
        MON_IDLE     = 2'b00, // nothing retired yet
        MON_WATCH    = 2'b01, // comparing, no divergence so far
        MON_DIVERGED = 2'b10  // sticky until reset
    } monitor_state_t;

endpackage

// ==== design/prog_mem.sv ====
// program memory: two instruction banks, loaded by strobe, read by each core's pc
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module prog_mem (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    prog_we,
    input  logic                    prog_bank,
    input  lockstep_pkg::mem_index_t prog_addr,
    input  lockstep_pkg::word_t     prog_data,
    input  lockstep_pkg::word_t     pc_a,
    input  lockstep_pkg::word_t     pc_b,
    output lockstep_pkg::word_t     instr_a,
    output lockstep_pkg::word_t     instr_b
);
    import lockstep_pkg::*;

    // bank 0 feeds core a, bank 1 feeds core b
    word_t bank_a [`IMEM_WORDS];
    word_t bank_b [`IMEM_WORDS];

    mem_index_t idx_a;
    mem_index_t idx_b;

    // contents survive reset, but no loads are taken while reset is asserted
    always_ff @(posedge clk) begin
        if (prog_we && arst_n) begin
            if (prog_bank) begin
                bank_b[prog_addr] <= prog_data;
            end else begin
                bank_a[prog_addr] <= prog_data;
            end
        end
    end

    assign idx_a = pc_a[5:2]; // word aligned fetch
    assign idx_b = pc_b[5:2];

    // combinational fetch, one port per core
    assign instr_a = bank_a[idx_a];
    assign instr_b = bank_b[idx_b];

endmodule

// ==== design/mini_core.sv ====
// mini_core: single-cycle RV32 subset (addi, load, store) with a retirement trace
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module mini_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  lockstep_pkg::word_t     instr,
    output lockstep_pkg::word_t     pc,
    output logic                    retire,
    output logic                    wb_en,
    output lockstep_pkg::reg_addr_t wb_addr,
    output lockstep_pkg::word_t     wb_data,
    output logic                    lb_valid,
    output lockstep_pkg::word_t     lb_addr
);
    import lockstep_pkg::*;

    localparam logic [2:0] F3_WORD = 3'b000;

    word_t regs [32];
    word_t dmem [`DMEM_WORDS];

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      sum_i;    // addi result and load address
    word_t      sum_s;    // store address
    mem_index_t ld_idx;
    mem_index_t st_idx;
    mem_index_t pc_idx;
    logic       is_addi;
    logic       is_load;
    logic       is_store;
    logic       wr_en;
    word_t      wr_data;

    // field decode
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    assign is_addi  = (opcode == OP_ADDI) && (funct3 == F3_WORD);
    assign is_load  = (opcode == OP_LOAD) && (funct3 == F3_WORD);
    assign is_store = (opcode == OP_STORE);

    // x0 is never written, so it reads as zero
    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

    assign sum_i  = rs1_val + imm_i;
    assign sum_s  = rs1_val + imm_s;
    assign ld_idx = sum_i[5:2];
    assign st_idx = sum_s[5:2];

    assign wr_en   = (is_addi || is_load) && (rd != 5'd0);
    assign wr_data = is_load ? dmem[ld_idx] : sum_i;

    assign pc_idx = pc[5:2] + 4'd1; // wraps over 16 words

    // architectural state and trace control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            retire   <= 1'b0;
            wb_en    <= 1'b0;
            lb_valid <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (run) begin
            pc     <= {26'd0, pc_idx, 2'b00};
            retire <= 1'b1;
            wb_en  <= wr_en;
            if (wr_en) begin
                regs[rd] <= wr_data;
            end
            if (is_store) begin
                dmem[st_idx] <= rs2_val;
            end
            if (is_load) begin
                lb_valid <= 1'b1; // sticky load table entry
            end
        end else begin
            retire <= 1'b0; // frozen, nothing retires
            wb_en  <= 1'b0;
        end
    end

    // trace payload, qualified by wb_en and lb_valid
    always_ff @(posedge clk) begin
        if (run) begin
            wb_addr <= rd;
            wb_data <= wr_data;
            if (is_load) begin
                lb_addr <= sum_i; // most recent load only
            end
        end
    end

endmodule

// ==== design/divergence_monitor.sv ====
// divergence monitor: compares two retirement traces and records the first divergence
`timescale 1ns/1ps

module divergence_monitor (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     retire_a,
    input  logic                     wb_en_a,
    input  lockstep_pkg::reg_addr_t  wb_addr_a,
    input  lockstep_pkg::word_t      wb_data_a,
    input  logic                     lb_valid_a,
    input  lockstep_pkg::word_t      lb_addr_a,
    input  logic                     wb_en_b,
    input  lockstep_pkg::reg_addr_t  wb_addr_b,
    input  lockstep_pkg::word_t      wb_data_b,
    input  logic                     lb_valid_b,
    input  lockstep_pkg::word_t      lb_addr_b,
    output logic                     lb_diverge,
    output logic                     wb_diverge,
    output logic                     diverge_seen,
    output lockstep_pkg::cycle_cnt_t diverge_cycle
);
    import lockstep_pkg::*;

    monitor_state_t state;
    cycle_cnt_t     retire_count;
    logic           lb_mismatch;
    logic           wb_mismatch;
    logic           any_mismatch;

    // load table: valid flags, then address when both hold an entry
    assign lb_mismatch = (lb_valid_a != lb_valid_b) ||
                         (lb_valid_a && lb_valid_b && (lb_addr_a != lb_addr_b));

    assign wb_mismatch = (wb_en_a != wb_en_b) ||
                         (wb_en_a && wb_en_b &&
                          ((wb_addr_a != wb_addr_b) || (wb_data_a != wb_data_b)));

    assign any_mismatch = retire_a && (lb_mismatch || wb_mismatch);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= MON_IDLE;
            retire_count  <= '0;
            diverge_cycle <= '0;
            lb_diverge    <= 1'b0;
            wb_diverge    <= 1'b0;
        end else begin
            lb_diverge <= retire_a && lb_mismatch; // one-cycle pulses
            wb_diverge <= retire_a && wb_mismatch;
            if (retire_a) begin
                retire_count <= retire_count + 1'b1;
            end
            case (state)
                MON_IDLE, MON_WATCH: begin
                    if (any_mismatch) begin
                        state         <= MON_DIVERGED;
                        diverge_cycle <= retire_count; // count before this retire
                    end else if (retire_a) begin
                        state <= MON_WATCH;
                    end
                end
                default: state <= MON_DIVERGED; // held until reset
            endcase
        end
    end

    assign diverge_seen = (state == MON_DIVERGED);

endmodule

// ==== design/lockstep_top.sv ====
// lockstep top: program banks, two core copies and the divergence monitor
`timescale 1ns/1ps

module lockstep_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     run,
    input  logic                     prog_we,
    input  logic                     prog_bank,
    input  lockstep_pkg::mem_index_t prog_addr,
    input  lockstep_pkg::word_t      prog_data,
    output logic                     lb_diverge,
    output logic                     wb_diverge,
    output logic                     diverge_seen,
    output lockstep_pkg::cycle_cnt_t diverge_cycle
);
    import lockstep_pkg::*;

    word_t     pc_a;
    word_t     pc_b;
    word_t     instr_a;
    word_t     instr_b;
    logic      retire_a;
    logic      wb_en_a;
    logic      wb_en_b;
    reg_addr_t wb_addr_a;
    reg_addr_t wb_addr_b;
    word_t     wb_data_a;
    word_t     wb_data_b;
    logic      lb_valid_a;
    logic      lb_valid_b;
    word_t     lb_addr_a;
    word_t     lb_addr_b;

    prog_mem i_prog_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_bank (prog_bank),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc_a      (pc_a),
        .pc_b      (pc_b),
        .instr_a   (instr_a),
        .instr_b   (instr_b)
    );

    mini_core i_core_a (
        .clk (clk), .arst_n (arst_n), .run (run), .instr (instr_a), .pc (pc_a),
        .retire (retire_a), .wb_en (wb_en_a), .wb_addr (wb_addr_a), .wb_data (wb_data_a),
        .lb_valid (lb_valid_a), .lb_addr (lb_addr_a)
    );

    // same run level, so core b retires in the same cycles as core a
    mini_core i_core_b (
        .clk (clk), .arst_n (arst_n), .run (run), .instr (instr_b), .pc (pc_b),
        .retire (), .wb_en (wb_en_b), .wb_addr (wb_addr_b), .wb_data (wb_data_b),
        .lb_valid (lb_valid_b), .lb_addr (lb_addr_b)
    );

    divergence_monitor i_divergence_monitor (
        .clk (clk), .arst_n (arst_n), .retire_a (retire_a),
        .wb_en_a (wb_en_a), .wb_addr_a (wb_addr_a), .wb_data_a (wb_data_a),
        .lb_valid_a (lb_valid_a), .lb_addr_a (lb_addr_a),
        .wb_en_b (wb_en_b), .wb_addr_b (wb_addr_b), .wb_data_b (wb_data_b),
        .lb_valid_b (lb_valid_b), .lb_addr_b (lb_addr_b),
        .lb_diverge (lb_diverge), .wb_diverge (wb_diverge),
        .diverge_seen (diverge_seen), .diverge_cycle (diverge_cycle)
    );

endmodule

// ==== tests/lockstep_asserts.sv ====
// lockstep asserts: protocol checks on the divergence monitor outputs
`timescale 1ns/1ps

module lockstep_asserts (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     retire_a,
    input logic                     lb_diverge,
    input logic                     wb_diverge,
    input logic                     diverge_seen,
    input lockstep_pkg::cycle_cnt_t diverge_cycle
);

    // sticky flag
    seen_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        diverge_seen |=> diverge_seen)
        else $error("diverge_seen fell while out of reset");

    pulse_sets_seen: assert property (@(posedge clk) disable iff (!arst_n)
        (lb_diverge || wb_diverge) |=> diverge_seen)
        else $error("diverge pulse without diverge_seen afterwards");

    // pulses only follow a retire
    pulse_needs_retire: assert property (@(posedge clk) disable iff (!arst_n)
        (lb_diverge || wb_diverge) |-> $past(retire_a))
        else $error("diverge pulse without a retire on the previous cycle");

    reset_outputs_low: assert property (@(posedge clk)
        !arst_n |-> (!lb_diverge && !wb_diverge && !diverge_seen && diverge_cycle == '0))
        else $error("monitor outputs not cleared during reset");

endmodule

bind divergence_monitor lockstep_asserts i_lockstep_asserts (.*);

// ==== tests/tb_lockstep_top.sv ====
// lockstep testbench: random program pairs run against a two-core reference model
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module tb_lockstep_top;
    import lockstep_pkg::*;

    localparam int NUM_TESTS  = 8;
    localparam int RUN_CYCLES = 48;
    // run, reset and load slack per test plus room for run gaps
    localparam int WATCHDOG_NS = NUM_TESTS * (48 + 16 + 40) * 8 + NUM_TESTS * 48 * 8 + 2000;

    logic       clk;
    logic       arst_n;
    logic       run;
    logic       prog_we;
    logic       prog_bank;
    mem_index_t prog_addr;
    word_t      prog_data;
    logic       lb_diverge;
    logic       wb_diverge;
    logic       diverge_seen;
    cycle_cnt_t diverge_cycle;

    integer seed;
    int     errors;

    // reference model state with core a at index 0
    word_t      prog_m [2][`IMEM_WORDS];
    word_t      regs_m [2][32];
    word_t      dmem_m [2][`DMEM_WORDS];
    mem_index_t pc_m   [2];
    logic       lbv_m  [2];
    word_t      lba_m  [2];
    logic       ten_m  [2];
    reg_addr_t  tad_m  [2];
    word_t      tdt_m  [2];
    logic       tr_retire;
    logic       tr_lbm;
    logic       tr_wbm;
    logic       exp_lb;
    logic       exp_wb;
    logic       exp_seen;
    cycle_cnt_t exp_cycle;
    cycle_cnt_t ret_cnt;

    lockstep_top i_lockstep_top (
        .clk (clk), .arst_n (arst_n), .run (run), .prog_we (prog_we),
        .prog_bank (prog_bank), .prog_addr (prog_addr), .prog_data (prog_data),
        .lb_diverge (lb_diverge), .wb_diverge (wb_diverge),
        .diverge_seen (diverge_seen), .diverge_cycle (diverge_cycle)
    );

    always #4 clk = ~clk; // 8 ns period

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input reg_addr_t rd, input opcode_t op);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic word_t enc_store(input logic [11:0] imm, input reg_addr_t rs2,
                                        input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OP_STORE};
    endfunction

    // one model instruction by the ISA rules
    task automatic exec_core(input int c);
        word_t      ins;
        word_t      imm_i;
        word_t      imm_s;
        word_t      addr;
        word_t      val;
        reg_addr_t  rd;
        ins   = prog_m[c][pc_m[c]];
        rd    = ins[11:7];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ten_m[c] = 1'b0;
        tad_m[c] = rd;
        tdt_m[c] = '0;
        if (ins[6:0] == OP_ADDI && ins[14:12] == 3'b000) begin
            val = regs_m[c][ins[19:15]] + imm_i;
            ten_m[c] = (rd != 5'd0);
            tdt_m[c] = val;
        end else if (ins[6:0] == OP_LOAD && ins[14:12] == 3'b000) begin
            addr = regs_m[c][ins[19:15]] + imm_i;
            val  = dmem_m[c][addr[5:2]];
            lbv_m[c] = 1'b1;
            lba_m[c] = addr;
            ten_m[c] = (rd != 5'd0);
            tdt_m[c] = val;
        end else if (ins[6:0] == OP_STORE) begin
            addr = regs_m[c][ins[19:15]] + imm_s;
            dmem_m[c][addr[5:2]] = regs_m[c][ins[24:20]];
        end
        if (ten_m[c]) begin
            regs_m[c][rd] = tdt_m[c];
        end
        pc_m[c] = pc_m[c] + 4'd1; // wraps over 16 words
    endtask

    // model trace stage with the monitor stage one edge later
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < 2; c++) begin
                for (int i = 0; i < 32; i++) begin
                    regs_m[c][i] = '0;
                end
                for (int i = 0; i < `DMEM_WORDS; i++) begin
                    dmem_m[c][i] = '0;
                end
                pc_m[c]  = '0;
                lbv_m[c] = 1'b0;
                lba_m[c] = '0;
            end
            tr_retire = 1'b0;
            tr_lbm    = 1'b0;
            tr_wbm    = 1'b0;
            exp_lb    = 1'b0;
            exp_wb    = 1'b0;
            exp_seen  = 1'b0;
            exp_cycle = '0;
            ret_cnt   = '0;
        end else begin
            exp_lb = tr_retire && tr_lbm;
            exp_wb = tr_retire && tr_wbm;
            if ((exp_lb || exp_wb) && !exp_seen) begin
                exp_seen  = 1'b1;
                exp_cycle = ret_cnt; // first instruction counts as 0
            end
            if (tr_retire) begin
                ret_cnt = ret_cnt + 1'b1;
            end
            tr_retire = run;
            if (run) begin
                exec_core(0);
                exec_core(1);
                tr_lbm = (lbv_m[0] != lbv_m[1]) ||
                         (lbv_m[0] && lbv_m[1] && lba_m[0] != lba_m[1]);
                tr_wbm = (ten_m[0] != ten_m[1]) ||
                         (ten_m[0] && ten_m[1] &&
                          (tad_m[0] != tad_m[1] || tdt_m[0] != tdt_m[1]));
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (lb_diverge !== exp_lb) begin
            errors++;
            $display("FAILED t=%0t lb_diverge exp=%b got=%b", $time, exp_lb, lb_diverge);
        end
        if (wb_diverge !== exp_wb) begin
            errors++;
            $display("FAILED t=%0t wb_diverge exp=%b got=%b", $time, exp_wb, wb_diverge);
        end
        if (diverge_seen !== exp_seen) begin
            errors++;
            $display("FAILED t=%0t diverge_seen exp=%b got=%b", $time, exp_seen, diverge_seen);
        end
        if (diverge_cycle !== exp_cycle) begin
            errors++;
            $display("FAILED t=%0t diverge_cycle exp=%0d got=%0d", $time, exp_cycle,
                     diverge_cycle);
        end
    end

    task automatic rand_instr(output word_t ins);
        logic [31:0] r;
        r = $random(seed);
        case (r[22:21])
            2'd0: ins = enc_i(r[20:9], {2'b00, r[5:3]}, {2'b00, r[2:0]}, OP_ADDI);
            2'd1: ins = enc_i(r[20:9], {2'b00, r[5:3]}, {2'b00, r[2:0]}, OP_LOAD);
            2'd2: ins = enc_store(r[20:9], {2'b00, r[8:6]}, {2'b00, r[5:3]});
            default: ins = enc_i(r[20:9], {2'b00, r[5:3]}, {2'b00, r[2:0]}, 7'b0110011);
        endcase
    endtask

    // kind 0 same, 1 load imm, 2 addi imm, 3 store imm
    task automatic make_programs(input int kind);
        logic [31:0] r;
        word_t       ins;
        mem_index_t  j;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            rand_instr(ins);
            prog_m[0][i] = ins;
            prog_m[1][i] = ins;
        end
        r = $random(seed);
        j = r[3:0];
        case (kind)
            1: begin
                prog_m[0][j] = enc_i(r[15:4], {2'b00, r[18:16]}, {2'b00, r[21:19]}, OP_LOAD);
                prog_m[1][j] = enc_i(r[15:4] ^ 12'h004, {2'b00, r[18:16]}, {2'b00, r[21:19]},
                                     OP_LOAD);
            end
            2: begin
                prog_m[0][j] = enc_i(r[15:4], {2'b00, r[18:16]}, {2'b00, r[21:19]}, OP_ADDI);
                prog_m[1][j] = enc_i(r[15:4] ^ 12'h001, {2'b00, r[18:16]}, {2'b00, r[21:19]},
                                     OP_ADDI);
            end
            3: begin
                prog_m[0][j] = enc_store(r[15:4], {2'b00, r[18:16]}, {2'b00, r[21:19]});
                prog_m[1][j] = enc_store(r[15:4] ^ 12'h004, {2'b00, r[18:16]},
                                         {2'b00, r[21:19]});
            end
            default: ;
        endcase
    endtask

    task automatic load_banks();
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < `IMEM_WORDS; i++) begin
                @(posedge clk);
                prog_we   <= 1'b1;
                prog_bank <= b[0];
                prog_addr <= mem_index_t'(i);
                prog_data <= prog_m[b][i];
            end
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic run_program(input logic gaps);
        logic [31:0] r;
        int          n;
        n = 0;
        while (n < RUN_CYCLES) begin
            @(posedge clk);
            r = $random(seed);
            if (gaps && r[1:0] == 2'd0) begin
                run <= 1'b0; // random freeze
            end else begin
                run <= 1'b1;
                n++;
            end
        end
        @(posedge clk);
        run <= 1'b0;
        repeat (3) @(posedge clk); // drain trace and monitor stages
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation did not finish in %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed      = 47238;
        errors    = 0;
        clk       = 1'b0;
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_bank = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            make_programs(t % 4);
            load_banks();
            pulse_reset();
            run_program(t >= NUM_TESTS / 2); // second round freezes at random
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
design/lockstep_pkg.sv
design/prog_mem.sv
design/mini_core.sv
design/divergence_monitor.sv
design/lockstep_top.sv
tests/lockstep_asserts.sv
tests/tb_lockstep_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lockstep checker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_lockstep_top \
    -o sim_bin > build.log 2>&1 \
    && ./obj_dir/sim_bin > sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
